// ==== verilog/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Datapath widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5

// RV32I opcodes that touch data memory
`define OPCODE_LOAD     7'b0000011
`define OPCODE_STORE    7'b0100011

// Size field of funct3, bits 1:0
`define SIZE_BYTE       2'b00
`define SIZE_HALF       2'b01
`define SIZE_WORD       2'b10

// On-chip SRAM
`define SRAM_WORDS      1024    // Depth in 32-bit words
`define SRAM_LATENCY    2       // Accept edge to response pulse

`endif

// ==== verilog/mem_pkg.sv ====
`include "mem_config.svh"

package mem_pkg;

    // Pc, instruction, data and address words
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // Destination register index
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // One strobe bit per byte lane
    typedef logic [`DATA_WIDTH/8-1:0] wstrb_t;

    typedef logic [6:0] opcode_t;

    // Funct3 of a load or store
    // bit 2 set means zero extension, bits 1:0 give the size
    typedef logic [2:0] access_ctl_t;

    // SRAM slave FSM
    typedef enum logic [1:0] {
        IDLE,   // Ready for a request
        BUSY,   // Counting out the latency
        RESP    // Response pulse
    } sram_state_t;

endpackage

// ==== verilog/mem_stage.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module mem_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    // Instruction from execute
    input  logic                  valid_i,
    input  mem_pkg::word_t        pc_i,
    input  mem_pkg::word_t        inst_i,
    input  mem_pkg::word_t        result_i,
    input  mem_pkg::word_t        dmem_addr_i,
    input  mem_pkg::word_t        rs2_data_i,
    input  mem_pkg::reg_addr_t    rd_addr_i,
    output logic                  busy_o,
    // SRAM request side
    output logic                  awvalid_o,
    input  logic                  awready_i,
    output mem_pkg::word_t        awaddr_o,
    output mem_pkg::word_t        wdata_o,
    output mem_pkg::wstrb_t       wstrb_o,
    output logic                  arvalid_o,
    input  logic                  arready_i,
    output mem_pkg::word_t        araddr_o,
    // SRAM response side
    input  logic                  bvalid_i,
    input  logic                  rvalid_i,
    // Towards writeback
    output logic                  done_o,
    output mem_pkg::word_t        pc_o,
    output mem_pkg::word_t        inst_o,
    output mem_pkg::word_t        result_o,
    output mem_pkg::reg_addr_t    rd_addr_o,
    output mem_pkg::access_ctl_t  ctl_o,
    output logic                  is_load_o,
    output logic [1:0]            addr_lo_o
);
    import mem_pkg::*;

    // Held instruction
    word_t        pc_q;
    word_t        inst_q;
    word_t        result_q;
    word_t        addr_q;
    word_t        rs2_q;
    reg_addr_t    rd_q;
    access_ctl_t  ctl_q;
    logic         is_load_q;
    logic         is_store_q;

    // Control state
    logic         busy_q;
    logic         req_pend_q;

    // Decode of the incoming word
    opcode_t      opcode;
    access_ctl_t  funct3;
    logic         is_load_d;
    logic         is_store_d;

    logic         capture;
    logic         req_fire;
    logic         resp_seen;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign capture = valid_i && !busy_q;   // Strobes while busy are dropped

    always_comb begin
        is_load_d  = 1'b0;
        is_store_d = 1'b0;
        if (opcode == `OPCODE_LOAD) begin
            case (funct3)
                3'b000, 3'b001, 3'b010, 3'b100, 3'b101: is_load_d = 1'b1;
                default: is_load_d = 1'b0;
            endcase
        end
        if (opcode == `OPCODE_STORE) begin
            case (funct3)
                3'b000, 3'b001, 3'b010: is_store_d = 1'b1;
                default: is_store_d = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pc_q       <= pc_i;
            inst_q     <= inst_i;
            result_q   <= result_i;
            addr_q     <= dmem_addr_i;
            rs2_q      <= rs2_data_i;
            rd_q       <= rd_addr_i;
            ctl_q      <= funct3;
            is_load_q  <= is_load_d;
            is_store_q <= is_store_d;
        end
    end

    // Store lane placement
    always_comb begin
        case (ctl_q[1:0])
            `SIZE_BYTE: wstrb_o = wstrb_t'(4'b0001) << addr_q[1:0];
            `SIZE_HALF: wstrb_o = wstrb_t'(4'b0011) << {addr_q[1], 1'b0};
            default:    wstrb_o = wstrb_t'(4'b1111);
        endcase
    end

    assign wdata_o   = rs2_q << {addr_q[1:0], 3'b000};
    assign awaddr_o  = addr_q;
    assign araddr_o  = addr_q;
    assign awvalid_o = req_pend_q && is_store_q;
    assign arvalid_o = req_pend_q && is_load_q;

    assign req_fire  = (awvalid_o && awready_i) || (arvalid_o && arready_i);
    assign resp_seen = (is_store_q && bvalid_i) || (is_load_q && rvalid_i);

    // Non-memory ops finish right away
    assign done_o = busy_q && (!(is_load_q || is_store_q) || resp_seen);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            req_pend_q <= 1'b0;
        end else begin
            if (done_o) begin
                busy_q <= 1'b0;
            end else if (capture) begin
                busy_q <= 1'b1;
            end
            if (capture) begin
                req_pend_q <= is_load_d || is_store_d;
            end else if (req_fire) begin
                req_pend_q <= 1'b0;   // Request taken by the SRAM
            end
        end
    end

    assign busy_o    = busy_q;
    assign pc_o      = pc_q;
    assign inst_o    = inst_q;
    assign result_o  = result_q;
    assign rd_addr_o = rd_q;
    assign ctl_o     = ctl_q;
    assign is_load_o = is_load_q;
    assign addr_lo_o = addr_q[1:0];

endmodule

// ==== verilog/sram_axi4_lite.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module sram_axi4_lite (
    input  logic             clk,
    input  logic             rst_i,
    // Write address and data travel together
    input  logic             awvalid_i,
    output logic             awready_o,
    input  mem_pkg::word_t   awaddr_i,
    input  mem_pkg::word_t   wdata_i,
    input  mem_pkg::wstrb_t  wstrb_i,
    output logic             bvalid_o,
    // Read channel
    input  logic             arvalid_i,
    output logic             arready_o,
    input  mem_pkg::word_t   araddr_i,
    output logic             rvalid_o,
    output mem_pkg::word_t   rdata_o
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int CNT_W = $clog2(`SRAM_LATENCY + 1);

    word_t             mem_q [`SRAM_WORDS];
    word_t             rdata_q;     // Word as seen at acceptance
    sram_state_t       state_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              rd_q;        // Outstanding access is a read

    logic              idle;
    logic              aw_fire;
    logic              ar_fire;
    logic [IDX_W-1:0]  aw_idx;
    logic [IDX_W-1:0]  ar_idx;

    assign idle    = (state_q == IDLE);
    assign aw_fire = awvalid_i && idle;
    assign ar_fire = arvalid_i && idle && !awvalid_i;   // Write wins a tie

    assign aw_idx  = awaddr_i[IDX_W+1:2];
    assign ar_idx  = araddr_i[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            rd_q    <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (aw_fire || ar_fire) begin
                        state_q <= (`SRAM_LATENCY > 1) ? BUSY : RESP;
                        cnt_q   <= CNT_W'(1);
                        rd_q    <= ar_fire;
                    end
                end
                BUSY: begin
                    if (cnt_q == CNT_W'(`SRAM_LATENCY - 1)) begin
                        state_q <= RESP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RESP: begin
                    state_q <= IDLE;   // Single-cycle response
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Array access on the accepting edge
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            for (int i = 0; i < `DATA_WIDTH / 8; i++) begin
                if (wstrb_i[i]) begin
                    mem_q[aw_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
        if (ar_fire) begin
            rdata_q <= mem_q[ar_idx];
        end
    end

    assign awready_o = idle;
    assign arready_o = idle;
    assign bvalid_o  = (state_q == RESP) && !rd_q;
    assign rvalid_o  = (state_q == RESP) && rd_q;
    assign rdata_o   = rdata_q;

endmodule

// ==== verilog/wb_align_stage.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module wb_align_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  done_i,
    input  logic                  is_load_i,
    input  mem_pkg::access_ctl_t  ctl_i,
    input  logic [1:0]            addr_lo_i,
    input  mem_pkg::word_t        rdata_i,      // Raw SRAM word
    input  mem_pkg::word_t        pc_i,
    input  mem_pkg::word_t        inst_i,
    input  mem_pkg::word_t        result_i,
    input  mem_pkg::reg_addr_t    rd_addr_i,
    output logic                  wb_valid_o,
    output mem_pkg::word_t        pc_o,
    output mem_pkg::word_t        inst_o,
    output mem_pkg::word_t        result_o,
    output mem_pkg::word_t        dmem_rdata_o,
    output mem_pkg::reg_addr_t    rd_addr_o
);
    import mem_pkg::*;

    word_t  shifted;
    word_t  aligned;
    logic   zext;

    assign zext    = ctl_i[2];
    assign shifted = rdata_i >> {addr_lo_i, 3'b000};   // Wanted lane down to bit 0

    always_comb begin
        case (ctl_i[1:0])
            `SIZE_BYTE: begin
                aligned = {{(`DATA_WIDTH-8){shifted[7] & ~zext}}, shifted[7:0]};
            end
            `SIZE_HALF: begin
                aligned = {{(`DATA_WIDTH-16){shifted[15] & ~zext}}, shifted[15:0]};
            end
            default: begin
                aligned = shifted;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (done_i) begin
            pc_o         <= pc_i;
            inst_o       <= inst_i;
            result_o     <= result_i;
            rd_addr_o    <= rd_addr_i;
            dmem_rdata_o <= is_load_i ? aligned : '0;   // Only loads carry data
        end
    end

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                valid_i,
    input  mem_pkg::word_t      pc_i,
    input  mem_pkg::word_t      inst_i,
    input  mem_pkg::word_t      result_i,
    input  mem_pkg::word_t      dmem_addr_i,
    input  mem_pkg::word_t      rs2_data_i,
    input  mem_pkg::reg_addr_t  rd_addr_i,
    output logic                busy_o,
    output logic                wb_valid_o,
    output mem_pkg::word_t      pc_o,
    output mem_pkg::word_t      inst_o,
    output mem_pkg::word_t      result_o,
    output mem_pkg::word_t      dmem_rdata_o,
    output mem_pkg::reg_addr_t  rd_addr_o
);
    import mem_pkg::*;

    // SRAM bus
    logic         awvalid;
    logic         awready;
    word_t        awaddr;
    word_t        wdata;
    wstrb_t       wstrb;
    logic         bvalid;
    logic         arvalid;
    logic         arready;
    word_t        araddr;
    logic         rvalid;
    word_t        rdata;

    // Memory stage to writeback
    logic         mem_access_done;
    word_t        mem_pc;
    word_t        mem_inst;
    word_t        mem_result;
    reg_addr_t    mem_rd_addr;
    access_ctl_t  mem_ctl;
    logic         mem_is_load;
    logic [1:0]   mem_addr_lo;

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .result_i    (result_i),
        .dmem_addr_i (dmem_addr_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .busy_o      (busy_o),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .awaddr_o    (awaddr),
        .wdata_o     (wdata),
        .wstrb_o     (wstrb),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .araddr_o    (araddr),
        .bvalid_i    (bvalid),
        .rvalid_i    (rvalid),
        .done_o      (mem_access_done),
        .pc_o        (mem_pc),
        .inst_o      (mem_inst),
        .result_o    (mem_result),
        .rd_addr_o   (mem_rd_addr),
        .ctl_o       (mem_ctl),
        .is_load_o   (mem_is_load),
        .addr_lo_o   (mem_addr_lo)
    );

    sram_axi4_lite u_sram (
        .clk       (clk),
        .rst_i     (rst_i),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .awaddr_i  (awaddr),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .bvalid_o  (bvalid),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .araddr_i  (araddr),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata)
    );

    wb_align_stage u_wb_align (
        .clk          (clk),
        .rst_i        (rst_i),
        .done_i       (mem_access_done),
        .is_load_i    (mem_is_load),
        .ctl_i        (mem_ctl),
        .addr_lo_i    (mem_addr_lo),
        .rdata_i      (rdata),          // Straight from the SRAM
        .pc_i         (mem_pc),
        .inst_i       (mem_inst),
        .result_i     (mem_result),
        .rd_addr_i    (mem_rd_addr),
        .wb_valid_o   (wb_valid_o),
        .pc_o         (pc_o),
        .inst_o       (inst_o),
        .result_o     (result_o),
        .dmem_rdata_o (dmem_rdata_o),
        .rd_addr_o    (rd_addr_o)
    );

endmodule

// ==== bench/mem_subsys_tb.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int    IDX_W    = $clog2(`SRAM_WORDS);
    localparam int    TIMEOUT  = 50;               // Cycles allowed for any wait
    localparam int    N_WORDS  = 16;               // Small SRAM window in use
    localparam int    N_RANDOM = 300;
    localparam word_t BASE     = 32'h0000_0100;

    logic       clk;
    logic       rst_i;
    logic       valid_i;
    word_t      pc_i;
    word_t      inst_i;
    word_t      result_i;
    word_t      dmem_addr_i;
    word_t      rs2_data_i;
    reg_addr_t  rd_addr_i;
    logic       busy_o;
    logic       wb_valid_o;
    word_t      pc_o;
    word_t      inst_o;
    word_t      result_o;
    word_t      dmem_rdata_o;
    reg_addr_t  rd_addr_o;

    word_t      shadow [`SRAM_WORDS];   // Expected SRAM contents
    integer     seed;
    int         sent_count = 0;
    int         wb_count = 0;

    mem_subsys_top dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .result_i     (result_i),
        .dmem_addr_i  (dmem_addr_i),
        .rs2_data_i   (rs2_data_i),
        .rd_addr_i    (rd_addr_i),
        .busy_o       (busy_o),
        .wb_valid_o   (wb_valid_o),
        .pc_o         (pc_o),
        .inst_o       (inst_o),
        .result_o     (result_o),
        .dmem_rdata_o (dmem_rdata_o),
        .rd_addr_o    (rd_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Every writeback pulse, wanted or not
    always @(posedge clk) begin
        if (!rst_i && wb_valid_o === 1'b1) begin
            wb_count <= wb_count + 1;
        end
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic word_t make_inst(input word_t upper, input logic [6:0] opc,
                                        input logic [2:0] f3, input reg_addr_t rd);
        return {upper[31:15], f3, rd, opc};
    endfunction

    function automatic word_t word_addr(input int idx, input logic [1:0] off);
        return BASE + word_t'(idx * 4) + word_t'(off);
    endfunction

    // RV32I load result from the shadow word
    function automatic word_t load_value(input word_t addr, input logic [2:0] f3);
        word_t        w;
        logic [7:0]   b;
        logic [15:0]  h;
        w = shadow[addr[IDX_W+1:2]];
        b = w[addr[1:0]*8 +: 8];
        h = w[addr[1]*16 +: 16];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'h0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic write_shadow(input word_t addr, input logic [2:0] f3, input word_t data);
        logic [IDX_W-1:0] idx;
        idx = addr[IDX_W+1:2];
        case (f3[1:0])
            `SIZE_BYTE: shadow[idx][addr[1:0]*8 +: 8] = data[7:0];
            `SIZE_HALF: shadow[idx][addr[1]*16 +: 16] = data[15:0];
            default:    shadow[idx] = data;
        endcase
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy_o !== 1'b0 && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (busy_o === 1'b0) else begin
            stop_with_failure("Timeout while waiting for busy_o to fall");
        end
    endtask

    // One instruction from strobe to writeback
    task automatic run_instr(input word_t pc, input word_t inst, input word_t result,
                             input word_t addr, input word_t rs2, input reg_addr_t rd,
                             input word_t exp_rdata, input bit is_mem);
        int cycles;
        int exp_cycles;
        exp_cycles = is_mem ? 2 + `SRAM_LATENCY : 2;
        wait_not_busy();
        valid_i     = 1'b1;
        pc_i        = pc;
        inst_i      = inst;
        result_i    = result;
        dmem_addr_i = addr;
        rs2_data_i  = rs2;
        rd_addr_i   = rd;
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        sent_count++;
        cycles = 1;
        while (wb_valid_o !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (wb_valid_o === 1'b1) else begin
            stop_with_failure("Timeout while waiting for wb_valid_o");
        end
        check_value("wb_valid_o latency", word_t'(cycles), word_t'(exp_cycles));
        check_value("pc_o", pc_o, pc);
        check_value("inst_o", inst_o, inst);
        check_value("result_o", result_o, result);
        check_value("rd_addr_o", word_t'(rd_addr_o), word_t'(rd));
        check_value("dmem_rdata_o", dmem_rdata_o, exp_rdata);
    endtask

    task automatic do_store(input logic [2:0] f3, input word_t addr, input word_t data);
        word_t r;
        word_t pc;
        r  = $random(seed);
        pc = $random(seed);
        pc[1:0] = 2'b00;
        run_instr(pc, make_inst(r, `OPCODE_STORE, f3, r[4:0]), addr, addr, data,
                  r[4:0], '0, 1'b1);
        write_shadow(addr, f3, data);
    endtask

    task automatic do_load(input logic [2:0] f3, input word_t addr);
        word_t r;
        word_t pc;
        r  = $random(seed);
        pc = $random(seed);
        pc[1:0] = 2'b00;
        run_instr(pc, make_inst(r, `OPCODE_LOAD, f3, r[4:0]), addr, addr, $random(seed),
                  r[4:0], load_value(addr, f3), 1'b1);
    endtask

    // ALU, LUI or JAL style word, no memory access
    task automatic do_alu();
        word_t       r;
        logic [6:0]  opc;
        r = $random(seed);
        case (r[1:0])
            2'd0:    opc = 7'b0110011;
            2'd1:    opc = 7'b0010011;
            2'd2:    opc = 7'b0110111;
            default: opc = 7'b1101111;
        endcase
        run_instr($random(seed), make_inst(r, opc, r[14:12], r[11:7]), $random(seed),
                  $random(seed), $random(seed), r[11:7], '0, 1'b0);
    endtask

    initial begin
        int     i;
        int     k;
        word_t  r;
        word_t  a;
        seed        = 32'h5e14_7bd5;
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        pc_i        = '0;
        inst_i      = '0;
        result_i    = '0;
        dmem_addr_i = '0;
        rs2_data_i  = '0;
        rd_addr_i   = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Quiet after reset
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            check_value("busy_o", word_t'(busy_o), '0);
            check_value("wb_valid_o", word_t'(wb_valid_o), '0);
        end

        for (i = 0; i < 4; i++) begin
            do_alu();
        end

        // Fill the window, read each word back
        for (i = 0; i < N_WORDS; i++) begin
            a = word_addr(i, 2'b00);
            do_store(3'b010, a, $random(seed));
            do_load(3'b010, a);
        end

        // Byte and halfword lanes
        for (i = 0; i < 4; i++) begin
            for (k = 0; k < 4; k++) begin
                do_store(3'b000, word_addr(i, 2'(k)), $random(seed));
                do_load(3'b010, word_addr(i, 2'b00));
            end
            do_store(3'b001, word_addr(i, 2'b00), $random(seed));
            do_load(3'b010, word_addr(i, 2'b00));
            do_store(3'b001, word_addr(i, 2'b10), $random(seed));
            do_load(3'b010, word_addr(i, 2'b00));
        end

        // Sign bits set and clear in every lane
        do_store(3'b010, word_addr(4, 2'b00), 32'h80ff_7f01);
        do_store(3'b010, word_addr(5, 2'b00), 32'h7fff_8000);
        for (i = 0; i < 6; i++) begin
            for (k = 0; k < 4; k++) begin
                do_load(3'b000, word_addr(i, 2'(k)));
                do_load(3'b100, word_addr(i, 2'(k)));
            end
            for (k = 0; k < 4; k += 2) begin
                do_load(3'b001, word_addr(i, 2'(k)));
                do_load(3'b101, word_addr(i, 2'(k)));
            end
        end

        for (k = 0; k < N_RANDOM; k++) begin
            r = $random(seed);
            if (r[5:4] == 2'b00) begin
                do_alu();
            end else begin
                case (r[8:6])
                    3'd0: do_load(3'b000, word_addr(int'(r[3:0]), r[10:9]));
                    3'd1: do_load(3'b100, word_addr(int'(r[3:0]), r[10:9]));
                    3'd2: do_load(3'b001, word_addr(int'(r[3:0]), {r[9], 1'b0}));
                    3'd3: do_load(3'b101, word_addr(int'(r[3:0]), {r[9], 1'b0}));
                    3'd4: do_load(3'b010, word_addr(int'(r[3:0]), 2'b00));
                    3'd5: do_store(3'b000, word_addr(int'(r[3:0]), r[10:9]), $random(seed));
                    3'd6: do_store(3'b001, word_addr(int'(r[3:0]), {r[9], 1'b0}),
                                   $random(seed));
                    default: do_store(3'b010, word_addr(int'(r[3:0]), 2'b00), $random(seed));
                endcase
            end
        end

        repeat (4) @(posedge clk);
        #1;
        check_value("wb_valid_o pulse count", word_t'(wb_count), word_t'(sent_count));
        check_value("busy_o", word_t'(busy_o), '0);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_stage.sv
verilog/sram_axi4_lite.sv
verilog/wb_align_stage.sv
verilog/mem_subsys_top.sv
bench/mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mem_subsys_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
